// ==== src.f ====
+incdir+hdl
hdl/lpc_pkg.sv
hdl/lpc_lane_if.sv
hdl/coef_update_lane.sv
hdl/alpha_reducer.sv
hdl/reflection_divider.sv
hdl/durbin_control.sv
hdl/levinson_top.sv
verif/levinson_checker.sv
verif/levinson_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= levinson_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0 --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
PASS_TEXT ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/levinson_tb.sv ====
/* Testbench for the Levinson-Durbin solver with LFSR-built frames,
   an integer model of the recursion and strobe by strobe comparison */
`include "lpc_macros.svh"

module levinson_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int O       = `LPC_ORDER;
    localparam int SIG_LEN = 24;
    localparam int FRAMES  = 5;
    localparam int TIMEOUT = 200;  // cycles per wait
    localparam lpc_pkg::coef_t UNITY = 1 << `LPC_FRAC;

    logic           iClock, arst_n, acf_valid;
    lpc_pkg::coef_t acf;
    logic           k_valid, coef_valid, done;
    lpc_pkg::coef_t k, error, coef;
    lpc_pkg::idx_t  coef_index;

    logic [31:0]    lfsr;
    lpc_pkg::coef_t r_in  [0:O];
    lpc_pkg::coef_t k_exp [1:O];
    lpc_pkg::coef_t e_exp [1:O];
    lpc_pkg::coef_t a_exp [0:O];

    levinson_top DUT (.*);

    bind levinson_top levinson_checker u_checker (
        .iClock(iClock), .arst_n(arst_n), .k_valid(k_valid),
        .coef_valid(coef_valid), .coef_index(coef_index), .done(done));

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // full product, floor shift, wrap
    function automatic lpc_pkg::coef_t q_product(input lpc_pkg::coef_t x, y);
        longint p;
        p = longint'(x) * longint'(y);
        return lpc_pkg::coef_t'(p >>> `LPC_FRAC);
    endfunction

    function automatic lpc_pkg::coef_t reflection(input lpc_pkg::coef_t alpha, e);
        longint mag, q;
        mag = (alpha < 0) ? -longint'(alpha) : longint'(alpha);
        q   = (mag << `LPC_FRAC) / longint'(e);
        return (alpha < 0) ? lpc_pkg::coef_t'(q) : lpc_pkg::coef_t'(-q);
    endfunction

    task automatic build_frame;
        int     x [0:SIG_LEN-1];
        longint acc;
        for (int n = 0; n < SIG_LEN; n++)
            x[n] = int'(take_bits(12)) - 2048;
        for (int j = 0; j <= O; j++) begin
            acc = 0;
            for (int n = 0; n + j < SIG_LEN; n++)
                acc += longint'(x[n]) * longint'(x[n + j]);
            r_in[j] = lpc_pkg::coef_t'(acc / SIG_LEN);  // biased
        end
        r_in[0] = r_in[0] + (r_in[0] >>> 3);
    endtask

    task automatic run_model;
        lpc_pkg::coef_t a     [0:O];
        lpc_pkg::coef_t a_old [0:O];
        lpc_pkg::coef_t e, alpha, kk, acc;
        a[0] = UNITY;
        for (int i = 1; i <= O; i++)
            a[i] = '0;
        e     = r_in[0];
        alpha = r_in[1];
        for (int m = 1; m <= O; m++) begin
            kk    = reflection(alpha, e);
            a_old = a;
            for (int i = 1; i <= m; i++)
                a[i] = a_old[i] + q_product(kk, a_old[m - i]);
            e        = e + q_product(kk, alpha);
            k_exp[m] = kk;
            e_exp[m] = e;
            if (m < O) begin
                acc = r_in[m + 1];
                for (int i = 1; i <= m; i++)
                    acc = acc + q_product(a[i], r_in[m + 1 - i]);
                alpha = acc;
            end
        end
        a_exp = a;
    endtask

    task automatic tick;
        @(posedge iClock);
        #2;
    endtask

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_k(input string name, input lpc_pkg::coef_t expected, actual);
        if (actual !== expected)
            report_failure($sformatf("Mismatch %s k: expected %0d, actual %0d",
                                     name, expected, actual));
    endtask

    task automatic check_error(input string name, input lpc_pkg::coef_t expected, actual);
        if (actual !== expected)
            report_failure($sformatf("Mismatch %s error: expected %0d, actual %0d",
                                     name, expected, actual));
    endtask

    task automatic check_coef(input string name, input lpc_pkg::coef_t expected, actual);
        if (actual !== expected)
            report_failure($sformatf("Mismatch %s coef: expected %0d, actual %0d",
                                     name, expected, actual));
    endtask

    task automatic check_index(input string name, input lpc_pkg::idx_t expected, actual);
        if (actual !== expected)
            report_failure($sformatf("Mismatch %s index: expected %0d, actual %0d",
                                     name, expected, actual));
    endtask

    task automatic load_frame;
        logic [31:0] gap;
        for (int j = 0; j <= O; j++) begin
            gap = take_bits(2);  // idle cycles before this strobe
            for (int g = 0; g < int'(gap); g++) begin
                acf_valid = 1'b0;
                tick();
            end
            acf_valid = 1'b1;
            acf       = r_in[j];
            tick();
        end
        acf_valid = 1'b0;
        acf       = '0;
    endtask

    task automatic collect_step(input int frame, input int step, input bit inject);
        int          cyc;
        logic [31:0] junk;
        string       name;
        name = $sformatf("frame %0d step %0d", frame, step);
        for (cyc = 0; cyc < TIMEOUT; cyc++) begin
            tick();
            junk      = inject ? take_bits(8) : '0;
            acf_valid = junk[0] & junk[1];  // stray strobe while busy
            acf       = lpc_pkg::coef_t'(junk);
            @(negedge iClock);
            if (coef_valid || done)
                report_failure($sformatf("coefficient readout began before %s", name));
            if (k_valid)
                break;
        end
        if (cyc == TIMEOUT)
            report_failure($sformatf("timed out waiting for k_valid in %s", name));
        check_k(name, k_exp[step], k);
        check_error(name, e_exp[step], error);
    endtask

    task automatic check_coef_stream(input int frame);
        int    cyc;
        string name;
        for (cyc = 0; cyc < TIMEOUT; cyc++) begin
            tick();
            acf_valid = 1'b0;
            @(negedge iClock);
            if (k_valid)
                report_failure($sformatf("extra k_valid pulse in frame %0d", frame));
            if (coef_valid)
                break;
        end
        if (cyc == TIMEOUT)
            report_failure($sformatf("timed out waiting for coef_valid in frame %0d", frame));
        for (int i = 1; i <= O; i++) begin
            name = $sformatf("frame %0d a[%0d]", frame, i);
            if (i > 1) begin
                tick();
                @(negedge iClock);
            end
            if (!coef_valid || done)
                report_failure($sformatf("coefficient stream broken at %s", name));
            check_index(name, lpc_pkg::idx_t'(i), coef_index);
            check_coef(name, a_exp[i], coef);
        end
        tick();
        @(negedge iClock);
        if (!done || coef_valid)
            report_failure($sformatf("no done pulse after last coefficient, frame %0d", frame));
        tick();
        @(negedge iClock);
        if (done)
            report_failure($sformatf("done held longer than one cycle in frame %0d", frame));
    endtask

    initial begin
        iClock = 1'b0;
        forever #20 iClock = ~iClock;
    end

    initial begin
        arst_n    = 1'b0;
        acf_valid = 1'b0;
        acf       = '0;
        lfsr      = 32'd96828;
        repeat (4) @(posedge iClock);
        #2 arst_n = 1'b1;
        repeat (2) tick();
        for (int f = 0; f < FRAMES; f++) begin
            build_frame();
            run_model();
            load_frame();
            for (int s = 1; s <= O; s++)
                collect_step(f, s, f % 2 == 1);  // odd frames get stray strobes
            check_coef_stream(f);
            repeat (3) tick();
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== verif/levinson_checker.sv ====
/* Output strobe assertions for the Levinson-Durbin solver, bound to the top */
`include "lpc_macros.svh"

module levinson_checker (
    input logic          iClock,
    input logic          arst_n,
    input logic          k_valid,
    input logic          coef_valid,
    input lpc_pkg::idx_t coef_index,
    input logic          done
);
    timeunit 1ns;
    timeprecision 1ps;

    // k stream and coefficient stream never overlap
    a_no_overlap: assert property (@(posedge iClock) disable iff (!arst_n)
        !(k_valid && coef_valid))
        else $error("k_valid and coef_valid high in the same cycle");

    a_done_pulse: assert property (@(posedge iClock) disable iff (!arst_n)
        done |=> !done)
        else $error("done held high for more than one cycle");

    a_index_range: assert property (@(posedge iClock) disable iff (!arst_n)
        coef_valid |-> (coef_index >= 1 && coef_index <= `LPC_ORDER))
        else $error("coef_index %0d outside 1..%0d", coef_index, `LPC_ORDER);

    a_quiet_in_reset: assert property (@(posedge iClock)
        !arst_n |-> !(k_valid || coef_valid || done))
        else $error("output strobe high while in reset");

endmodule

// ==== hdl/levinson_top.sv ====
/* Levinson-Durbin solver top: controller, serial divider,
   one update lane per coefficient and the alpha reducer */
`include "lpc_macros.svh"

module levinson_top (
    input  logic           iClock,
    input  logic           arst_n,
    input  logic           acf_valid,
    input  lpc_pkg::coef_t acf,
    output logic           k_valid,
    output lpc_pkg::coef_t k,
    output lpc_pkg::coef_t error,
    output logic           coef_valid,
    output lpc_pkg::idx_t  coef_index,
    output lpc_pkg::coef_t coef,
    output logic           done
);

    logic           div_start, div_done;
    lpc_pkg::coef_t div_alpha, div_error, div_k, div_error_next;
    logic           sum_start, alpha_valid;
    lpc_pkg::coef_t sum_base, alpha_sum;

    lpc_lane_if lane_bus [0:`LPC_ORDER-1] ();

    durbin_control u_ctrl (
        .iClock         (iClock),
        .arst_n         (arst_n),
        .acf_valid      (acf_valid),
        .acf            (acf),
        .lane           (lane_bus),
        .lane_fb        (lane_bus),
        .div_start      (div_start),
        .div_alpha      (div_alpha),
        .div_error      (div_error),
        .div_done       (div_done),
        .div_k          (div_k),
        .div_error_next (div_error_next),
        .sum_start      (sum_start),
        .sum_base       (sum_base),
        .alpha_valid    (alpha_valid),
        .alpha          (alpha_sum),
        .k_valid        (k_valid),
        .k              (k),
        .error          (error),
        .coef_valid     (coef_valid),
        .coef_index     (coef_index),
        .coef           (coef),
        .done           (done)
    );

    reflection_divider u_div (
        .iClock     (iClock),
        .arst_n     (arst_n),
        .start      (div_start),
        .alpha      (div_alpha),
        .error      (div_error),
        .done       (div_done),
        .k          (div_k),
        .error_next (div_error_next)
    );

    for (genvar g = 0; g < `LPC_ORDER; g++) begin : g_lane
        coef_update_lane u_lane (
            .iClock (iClock),
            .arst_n (arst_n),
            .port   (lane_bus[g])
        );
    end

    alpha_reducer u_red (
        .iClock      (iClock),
        .arst_n      (arst_n),
        .start       (sum_start),
        .base        (sum_base),
        .lanes       (lane_bus),
        .alpha_valid (alpha_valid),
        .alpha       (alpha_sum)
    );

endmodule

// ==== hdl/durbin_control.sv ====
/* Durbin recursion sequencer: loads r[0..ORDER], steps k/E, model
   update and alpha per order, then streams a[1..ORDER] out */
`include "lpc_macros.svh"

module durbin_control (
    input  logic           iClock,
    input  logic           arst_n,
    input  logic           acf_valid,
    input  lpc_pkg::coef_t acf,
    lpc_lane_if.ctrl       lane    [0:`LPC_ORDER-1],
    lpc_lane_if.back       lane_fb [0:`LPC_ORDER-1],
    output logic           div_start,
    output lpc_pkg::coef_t div_alpha,
    output lpc_pkg::coef_t div_error,
    input  logic           div_done,
    input  lpc_pkg::coef_t div_k,
    input  lpc_pkg::coef_t div_error_next,
    output logic           sum_start,
    output lpc_pkg::coef_t sum_base,
    input  logic           alpha_valid,
    input  lpc_pkg::coef_t alpha,
    output logic           k_valid,
    output lpc_pkg::coef_t k,
    output lpc_pkg::coef_t error,
    output logic           coef_valid,
    output lpc_pkg::idx_t  coef_index,
    output lpc_pkg::coef_t coef,
    output logic           done
);

    typedef enum logic [3:0] {
        S_LOAD,
        S_START,   // div_start
        S_DIV,
        S_UPDATE,  // k_valid, lane update
        S_WRITE,   // a_new write back
        S_SUM,     // sum_start
        S_ALPHA,
        S_OUT,
        S_DONE
    } state_t;

    state_t        state;
    lpc_pkg::idx_t load_cnt;
    lpc_pkg::idx_t m;        // current step
    lpc_pkg::idx_t out_idx;

    lpc_pkg::coef_t r_mem  [0:`LPC_ORDER];
    lpc_pkg::coef_t a_mem  [1:`LPC_ORDER];
    lpc_pkg::coef_t mirror [1:`LPC_ORDER];
    lpc_pkg::coef_t rterm  [1:`LPC_ORDER];
    lpc_pkg::coef_t a_back [1:`LPC_ORDER];
    lpc_pkg::coef_t k_r, err_r, alpha_r;

    logic upd;
    logic load_last;

    assign load_last = (state == S_LOAD) && acf_valid && (load_cnt == `LPC_ORDER);
    assign upd       = (state == S_UPDATE);

    assign div_start  = (state == S_START);
    assign div_alpha  = alpha_r;
    assign div_error  = err_r;
    assign sum_start  = (state == S_SUM);
    assign sum_base   = (int'(m) < `LPC_ORDER) ? r_mem[int'(m) + 1] : '0;
    assign k_valid    = upd;
    assign k          = k_r;
    assign error      = err_r;
    assign coef_valid = (state == S_OUT);
    assign coef_index = out_idx;
    assign coef       = a_mem[out_idx];
    assign done       = (state == S_DONE);

    // lane operands for step m, a[0] is 1.0
    always_comb begin
        for (int i = 1; i <= `LPC_ORDER; i++) begin
            if (i < int'(m))
                mirror[i] = a_mem[int'(m) - i];
            else if (i == int'(m))
                mirror[i] = lpc_pkg::ONE;
            else
                mirror[i] = '0;
            rterm[i] = (i <= int'(m)) ? r_mem[int'(m) + 1 - i] : '0;
        end
    end

    for (genvar g = 0; g < `LPC_ORDER; g++) begin : g_lane
        assign lane[g].update   = upd;
        assign lane[g].k        = k_r;
        assign lane[g].a_cur    = a_mem[g+1];
        assign lane[g].a_mirror = mirror[g+1];
        assign lane[g].r_term   = rterm[g+1];
        assign a_back[g+1]      = lane_fb[g].a_new;
    end

    always_ff @(posedge iClock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_LOAD;
            load_cnt <= '0;
            m        <= '0;
            out_idx  <= lpc_pkg::idx_t'(1);
        end else begin
            case (state)
                S_LOAD: begin
                    if (load_last) begin
                        load_cnt <= '0;
                        m        <= lpc_pkg::idx_t'(1);
                        state    <= S_START;
                    end else if (acf_valid) begin
                        load_cnt <= load_cnt + 1'b1;
                    end
                end
                S_START: state <= S_DIV;
                S_DIV: begin
                    if (div_done)
                        state <= S_UPDATE;
                end
                S_UPDATE: state <= S_WRITE;
                S_WRITE: state <= (m == `LPC_ORDER) ? S_OUT : S_SUM;
                S_SUM: state <= S_ALPHA;
                S_ALPHA: begin
                    if (alpha_valid) begin
                        m     <= m + 1'b1;
                        state <= S_START;
                    end
                end
                S_OUT: begin
                    if (out_idx == `LPC_ORDER) begin
                        out_idx <= lpc_pkg::idx_t'(1);
                        state   <= S_DONE;
                    end else begin
                        out_idx <= out_idx + 1'b1;
                    end
                end
                S_DONE: state <= S_LOAD;
                default: state <= S_LOAD;
            endcase
        end
    end

    always_ff @(posedge iClock) begin
        if (state == S_LOAD && acf_valid) begin
            r_mem[load_cnt] <= acf;
            if (load_cnt == 0)
                err_r <= acf;    // E = r[0]
            if (load_cnt == 1)
                alpha_r <= acf;  // alpha = r[1]
        end
        if (load_last) begin
            for (int i = 1; i <= `LPC_ORDER; i++)
                a_mem[i] <= '0;
        end
        if (state == S_DIV && div_done) begin
            k_r   <= div_k;
            err_r <= div_error_next;
        end
        if (state == S_WRITE) begin
            for (int i = 1; i <= `LPC_ORDER; i++)
                a_mem[i] <= a_back[i];
        end
        if (state == S_ALPHA && alpha_valid)
            alpha_r <= alpha;
    end

endmodule

// ==== hdl/reflection_divider.sv ====
/* Serial restoring divider: k = -alpha/E one quotient bit per cycle,
   then the new error E + k*alpha in the closing cycle */
`include "lpc_macros.svh"

module reflection_divider (
    input  logic           iClock,
    input  logic           arst_n,
    input  logic           start,
    input  lpc_pkg::coef_t alpha,
    input  lpc_pkg::coef_t error,
    output logic           done,
    output lpc_pkg::coef_t k,
    output lpc_pkg::coef_t error_next
);

    localparam int W  = `LPC_WIDTH;
    localparam int CW = $clog2(W + 1);

    logic           busy;
    logic [CW-1:0]  cnt;
    logic [W-1:0]   rem;
    logic [W-1:0]   lo;     // dividend bits still to shift in
    logic [W-1:0]   quo;
    logic [W-1:0]   mag;
    logic [2*W-1:0] dvd;
    logic [W:0]     rem_sh;
    logic [W:0]     diff;
    lpc_pkg::coef_t alpha_q, error_q, k_c;

    assign mag    = alpha[W-1] ? -alpha : alpha;
    assign dvd    = {{W{1'b0}}, mag} << `LPC_FRAC;
    assign rem_sh = {rem, lo[W-1]};
    assign diff   = rem_sh - {1'b0, error_q};  // msb set means no fit
    assign k_c    = alpha_q[W-1] ? quo : -quo;

    always_ff @(posedge iClock or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CW'(W);
            end else if (busy) begin
                if (cnt != 0) begin
                    cnt <= cnt - 1'b1;
                end else begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (start) begin
            rem     <= dvd[2*W-1:W];  // below E while |k| < 1
            lo      <= dvd[W-1:0];
            quo     <= '0;
            alpha_q <= alpha;
            error_q <= error;
        end else if (busy && cnt != 0) begin
            rem <= diff[W] ? rem_sh[W-1:0] : diff[W-1:0];
            lo  <= lo << 1;
            quo <= {quo[W-2:0], ~diff[W]};
        end else if (busy) begin
            k          <= k_c;
            error_next <= error_q + lpc_pkg::qmul(k_c, alpha_q);
        end
    end

endmodule

// ==== hdl/alpha_reducer.sv ====
/* Alpha reducer: base term plus every lane product, wrapping sum,
   registered with a one-cycle valid */
`include "lpc_macros.svh"

module alpha_reducer (
    input  logic           iClock,
    input  logic           arst_n,
    input  logic           start,
    input  lpc_pkg::coef_t base,
    lpc_lane_if.sink       lanes [0:`LPC_ORDER-1],
    output logic           alpha_valid,
    output lpc_pkg::coef_t alpha
);

    lpc_pkg::coef_t prod [0:`LPC_ORDER-1];
    lpc_pkg::coef_t total;

    for (genvar g = 0; g < `LPC_ORDER; g++) begin : g_tap
        assign prod[g] = lanes[g].product;
    end

    always_comb begin
        total = base;  // r[m+1]
        for (int i = 0; i < `LPC_ORDER; i++)
            total = total + prod[i];
    end

    always_ff @(posedge iClock or negedge arst_n) begin
        if (!arst_n)
            alpha_valid <= 1'b0;
        else
            alpha_valid <= start;
    end

    always_ff @(posedge iClock) begin
        if (start)
            alpha <= total;
    end

endmodule

// ==== hdl/coef_update_lane.sv ====
/* Coefficient lane: a[i] + k*a[m-i], then that result times r[m+1-i]
   for the alpha sum */
module coef_update_lane (
    input  logic     iClock,
    input  logic     arst_n,
    lpc_lane_if.lane port
);

    logic s2_en;  // stage 2 follows update

    always_ff @(posedge iClock or negedge arst_n) begin
        if (!arst_n)
            s2_en <= 1'b0;
        else
            s2_en <= port.update;
    end

    always_ff @(posedge iClock) begin
        if (port.update)
            port.a_new <= port.a_cur + lpc_pkg::qmul(port.k, port.a_mirror);
        if (s2_en)
            port.product <= lpc_pkg::qmul(port.a_new, port.r_term);
    end

endmodule

// ==== hdl/lpc_lane_if.sv ====
/* One coefficient lane: operands from the controller, updated
   coefficient back to it, alpha product to the reducer */
interface lpc_lane_if;

    logic           update;
    lpc_pkg::coef_t k;
    lpc_pkg::coef_t a_cur;     // a[i] before the step
    lpc_pkg::coef_t a_mirror;  // a[m-i]
    lpc_pkg::coef_t r_term;    // r[m+1-i]
    lpc_pkg::coef_t a_new;
    lpc_pkg::coef_t product;

    modport ctrl (
        output update, k, a_cur, a_mirror, r_term
    );

    modport lane (
        input  update, k, a_cur, a_mirror, r_term,
        output a_new, product
    );

    modport sink (input product);
    modport back (input a_new);

endinterface

// ==== hdl/lpc_pkg.sv ====
/* Fixed-point types shared by the Levinson-Durbin solver,
   plus the floor-product rule used by every multiplier */
`include "lpc_macros.svh"

package lpc_pkg;

    typedef logic signed [`LPC_WIDTH-1:0]   coef_t;  // Q word
    typedef logic signed [2*`LPC_WIDTH-1:0] prod_t;  // full product

    // holds 0..ORDER+1
    typedef logic [$clog2(`LPC_ORDER+2)-1:0] idx_t;

    localparam coef_t ONE = coef_t'(1 << `LPC_FRAC);

    // full signed product, floor shift, wrap to one word
    function automatic coef_t qmul(coef_t a, coef_t b);
        prod_t p;
        p = prod_t'(a) * prod_t'(b);
        return coef_t'(p >>> `LPC_FRAC);
    endfunction

endpackage

// ==== hdl/lpc_macros.svh ====
/* LPC solver parameters: prediction order and Q number format */
`ifndef LPC_MACROS_SVH
`define LPC_MACROS_SVH

// prediction order, one lane per coefficient
`define LPC_ORDER 12

// word width of r, a, k, E and alpha
`define LPC_WIDTH 32

`define LPC_FRAC 24  // fractional bits

`endif
